// ==== adc_trace.txt ====
# id vinp vinn ofs0 ofs1 ofs2 ofs3 en_slice alws_on init exp_sign exp_mag (decimal)
# rows with en_slice 0 expect no out_valid and ignore the last two columns
1 0 0 0 0 0 0 0 0 0 0 0
2 320 0 0 0 0 0 1 0 0 1 20
3 0 200 0 0 0 0 1 0 0 0 12
4 100 100 0 0 0 0 1 0 0 1 0
5 -500 -700 0 0 0 0 1 0 0 1 12
6 63 0 0 0 0 0 1 0 0 1 0
7 64 0 0 0 0 0 1 0 0 1 4
8 -64 0 0 0 0 0 1 0 0 0 4
9 -63 0 0 0 0 0 1 0 0 1 0
10 0 0 -96 -32 32 96 1 0 0 1 0
11 40 0 -96 -32 32 96 1 0 0 1 3
12 20 0 0 16 32 48 1 0 0 1 1
13 40 0 0 16 32 48 1 0 0 1 2
14 50 0 0 16 32 48 1 0 0 1 3
15 64 0 0 16 32 48 1 0 0 1 4
16 -70 0 0 16 32 48 1 0 0 0 1
17 2047 -2048 0 0 0 0 1 0 0 1 28
18 -2048 2047 0 0 0 0 1 0 0 0 28
19 2047 -2048 127 -128 127 -128 1 0 0 1 28
20 320 0 0 0 0 0 1 1 0 1 20
21 -128 0 0 0 0 0 1 1 0 0 8
22 40 0 0 16 32 48 1 1 0 1 2
23 130 0 0 0 0 0 1 0 2 1 8
24 0 0 0 0 0 0 0 0 2 0 0
25 -200 0 0 0 0 0 1 0 2 0 12
26 500 250 0 16 32 48 1 0 1 1 15

// ==== compile.f ====
+incdir+.
adc_pkg.sv
slice_sync.sv
slice_quantizer.sv
slice_adder.sv
stochastic_adc_top.sv
stochastic_adc_sva.sv
tb_stochastic_adc.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_stochastic_adc
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_stochastic_adc.sv ====
// reads adc_trace.txt from the run directory; each vector is checked on its second out_valid
`timescale 1ns/1ps

`include "adc_settings.svh"

module tb_stochastic_adc;

    localparam int RESET_CYCLES = 8;
    localparam int MAX_TESTS    = 64;
    localparam int N_RANDOM     = 8;
    localparam int TEST_CYCLES  = 20;
    localparam int VALID_WAIT   = 10;

    logic                                          clk_adder;
    logic                                          rstb;
    logic                                          en_slice;
    logic                                          en_sync_in;
    logic                                          alws_on;
    logic [`ADC_NDIV-1:0]                          init;
    logic signed [`ADC_IN_W-1:0]                   vinp;
    logic signed [`ADC_IN_W-1:0]                   vinn;
    logic signed [`ADC_NSLICE-1:0][`ADC_OFS_W-1:0] cal_offset;
    logic                                          en_sync_out;
    logic                                          sign_out;
    logic [`ADC_OUT_W-1:0]                         adder_out;
    logic                                          out_valid;

    // row layout id vinp vinn ofs0..ofs3 en_slice alws_on init sign mag
    integer vec [MAX_TESTS][12];
    integer cur [12];
    integer n_tests   = 0;
    integer n_run     = 0;
    integer n_bad     = 0;
    integer cycle_cnt = 0;
    integer seed      = 30;
    bit     finished  = 1'b0;
    bit     prev_en   = 1'b0;
    bit     prev_alws = 1'b0;

    stochastic_adc_top i_dut (
        .clk_adder   (clk_adder),
        .rstb        (rstb),
        .en_slice    (en_slice),
        .en_sync_in  (en_sync_in),
        .alws_on     (alws_on),
        .init        (init),
        .vinp        (vinp),
        .vinn        (vinn),
        .cal_offset  (cal_offset),
        .en_sync_out (en_sync_out),
        .sign_out    (sign_out),
        .adder_out   (adder_out),
        .out_valid   (out_valid)
    );

    initial begin : clock_gen
        clk_adder = 1'b0;
        forever #5 clk_adder = ~clk_adder;
    end

    always @(posedge clk_adder) cycle_cnt <= cycle_cnt + 1;

    ////////////////////
    // reference model
    ////////////////////

    // signed step of one slice for a corrected difference
    function automatic integer slice_step(input integer d);
        integer a;
        a = ((d < 0) ? -d : d) / (1 << `ADC_SLICE_SHIFT);
        if (a > (1 << (`ADC_SLICE_W - 1)) - 1)
            a = (1 << (`ADC_SLICE_W - 1)) - 1;
        return (d < 0) ? -a : a;
    endfunction

    task automatic predict_current();
        integer sum;
        integer k;
        sum = 0;
        for (k = 0; k < `ADC_NSLICE; k++)
            sum = sum + slice_step(cur[1] - cur[2] + cur[3 + k]);
        cur[10] = (sum >= 0) ? 1 : 0;
        cur[11] = (sum < 0) ? -sum : sum;
        if (cur[11] > (1 << (`ADC_OUT_W - 1)) - 1)
            cur[11] = (1 << (`ADC_OUT_W - 1)) - 1;
    endtask

    ////////////////////
    // helpers
    ////////////////////

    task automatic next_cycle();
        @(posedge clk_adder);
        #1;
    endtask

    task automatic compare_hex(input string name, input integer expected, input integer actual,
                               inout integer errs);
        if (expected !== actual) begin
            $display("mismatch %s in test %0d expected %0h actual %0h",
                     name, cur[0], expected, actual);
            errs = errs + 1;
        end
    endtask

    task automatic wait_valid(output bit seen);
        integer n;
        seen = 1'b0;
        for (n = 0; n < VALID_WAIT && !seen; n++) begin
            next_cycle();
            seen = out_valid;
        end
    endtask

    task automatic report_test(input integer errs);
        n_run = n_run + 1;
        if (errs != 0)
            n_bad = n_bad + 1;
        $display("test %0d: %s", cur[0], (errs == 0) ? "ok" : "has errors");
    endtask

    task automatic read_trace();
        integer fd;
        integer c;
        string  line;
        fd = $fopen("adc_trace.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open adc_trace.txt");
            return;
        end
        while (!$feof(fd) && n_tests < MAX_TESTS) begin
            line = "";
            c = $fgets(line, fd);
            if (c > 0 && line.substr(0, 0) != "#") begin
                c = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d",
                            vec[n_tests][0], vec[n_tests][1], vec[n_tests][2],
                            vec[n_tests][3], vec[n_tests][4], vec[n_tests][5],
                            vec[n_tests][6], vec[n_tests][7], vec[n_tests][8],
                            vec[n_tests][9], vec[n_tests][10], vec[n_tests][11]);
                if (c == 12)
                    n_tests = n_tests + 1;
            end
        end
        $fclose(fd);
    endtask

    // apply one vector, skip the result in flight, then check the next one
    task automatic run_current(output integer errs);
        bit     seen;
        integer first;
        integer k;
        errs     = 0;
        en_slice = cur[7][0];
        alws_on  = cur[8][0];
        init     = cur[9][`ADC_NDIV-1:0];
        vinp     = cur[1][`ADC_IN_W-1:0];
        vinn     = cur[2][`ADC_IN_W-1:0];
        for (k = 0; k < `ADC_NSLICE; k++)
            cal_offset[k] = cur[3 + k][`ADC_OFS_W-1:0];
        if (!en_slice) begin
            // samples already taken may still drain out
            repeat (3) next_cycle();
            repeat (TEST_CYCLES / 2) begin
                next_cycle();
                if (out_valid) begin
                    $display("error: out_valid seen while en_slice is low in test %0d", cur[0]);
                    errs = errs + 1;
                end
            end
        end else begin
            wait_valid(seen);
            first = cycle_cnt;
            if (seen)
                wait_valid(seen);
            if (!seen) begin
                $display("error: out_valid did not arrive within %0d cycles in test %0d",
                         VALID_WAIT, cur[0]);
                errs = errs + 1;
            end else begin
                compare_hex("sign_out", cur[10], 32'(sign_out), errs);
                compare_hex("adder_out", cur[11], 32'(adder_out), errs);
                // strobe spacing is fixed only once the mode has settled
                if (!prev_en || prev_alws == alws_on)
                    compare_hex("valid_gap", alws_on ? 1 : (1 << `ADC_NDIV),
                                cycle_cnt - first, errs);
            end
        end
        prev_en   = en_slice;
        prev_alws = alws_on;
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin : main
        integer i;
        integer k;
        integer errs;
        rstb       = 1'b0;
        en_slice   = 1'b0;
        en_sync_in = 1'b0;
        alws_on    = 1'b0;
        init       = '0;
        vinp       = '0;
        vinn       = '0;
        cal_offset = '0;
        read_trace();
        if (n_tests == 0) begin
            $display("error: no vectors were read from the trace file");
            n_bad = n_bad + 1;
        end
        repeat (RESET_CYCLES) next_cycle();
        rstb = 1'b1;

        // reset values, then the enable through its two flops
        cur[0] = 0;
        errs   = 0;
        compare_hex("en_sync_out", 0, 32'(en_sync_out), errs);
        compare_hex("out_valid", 0, 32'(out_valid), errs);
        compare_hex("sign_out", 0, 32'(sign_out), errs);
        compare_hex("adder_out", 0, 32'(adder_out), errs);
        en_sync_in = 1'b1;
        next_cycle();
        compare_hex("en_sync_out", 0, 32'(en_sync_out), errs);
        next_cycle();
        compare_hex("en_sync_out", 1, 32'(en_sync_out), errs);
        report_test(errs);

        for (i = 0; i < n_tests + N_RANDOM; i++) begin
            if (i < n_tests) begin
                for (k = 0; k < 12; k++)
                    cur[k] = vec[i][k];
            end else begin
                cur[0] = 100 + i - n_tests;
                cur[1] = $random(seed) % 2048;
                cur[2] = $random(seed) % 512;
                for (k = 0; k < `ADC_NSLICE; k++)
                    cur[3 + k] = $random(seed) % 128;
                cur[7] = 1;
                cur[8] = 0;
                cur[9] = 0;
                predict_current();
            end
            run_current(errs);
            report_test(errs);
        end

        finished = 1'b1;
        $display("tests run %0d, clean %0d, with errors %0d", n_run, n_run - n_bad, n_bad);
        if (n_bad == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // bounded by the number of vectors, counted from the release of reset
    initial begin : watchdog
        wait (rstb === 1'b1);
        repeat ((n_tests + N_RANDOM + 1) * TEST_CYCLES) @(posedge clk_adder);
        $display("error: run did not finish within its time budget at cycle %0d", cycle_cnt);
        finished = 1'b1;
        $display("Test failed");
        $finish;
    end

    final begin
        if (!finished)
            $display("Test failed");
    end

endmodule

// ==== stochastic_adc_sva.sv ====
// assumes en_sync_in is held low through reset; back to back results are legal only with alws_on
`timescale 1ns/1ps

`include "adc_settings.svh"

module stochastic_adc_sva (
    input logic                  clk_adder,
    input logic                  rstb,
    input logic                  en_sync_in,
    input logic                  alws_on,
    input logic                  sample_stb,
    input logic                  en_sync_out,
    input logic                  out_valid,
    input logic [`ADC_OUT_W-1:0] adder_out
);

    // a result reflects the strobe mode two or three cycles back
    a_valid_spacing: assert property (@(posedge clk_adder) disable iff (!rstb)
        (out_valid && $past(out_valid)) |-> ($past(alws_on, 2) || $past(alws_on, 3)))
        else $error("out_valid high in consecutive cycles without alws_on");

    // magnitude never exceeds every slice at full scale
    a_adder_clamp: assert property (@(posedge clk_adder) disable iff (!rstb)
        adder_out <= `ADC_NSLICE * ((1 << (`ADC_SLICE_W - 1)) - 1))
        else $error("adder_out above the full scale of all slices");

    a_sync_delay: assert property (@(posedge clk_adder) disable iff (!rstb)
        en_sync_out == $past(en_sync_in, 2))
        else $error("en_sync_out does not follow en_sync_in by two cycles");

    // quantizer stage then adder stage
    a_valid_latency: assert property (@(posedge clk_adder) disable iff (!rstb)
        out_valid == $past(sample_stb, 2))
        else $error("out_valid does not follow sample_stb by two cycles");

endmodule

bind stochastic_adc_top stochastic_adc_sva i_sva (
    .clk_adder   (clk_adder),
    .rstb        (rstb),
    .en_sync_in  (en_sync_in),
    .alws_on     (alws_on),
    .sample_stb  (sample_stb),
    .en_sync_out (en_sync_out),
    .out_valid   (out_valid),
    .adder_out   (adder_out)
);

// ==== stochastic_adc_top.sv ====
// inputs are digital codes and no noise is modeled, so the output is fully deterministic
`timescale 1ns/1ps

`include "adc_settings.svh"

module stochastic_adc_top (
    input  logic                                        clk_adder,
    input  logic                                        rstb,
    input  logic                                        en_slice,
    input  logic                                        en_sync_in,
    input  logic                                        alws_on,
    input  logic [`ADC_NDIV-1:0]                        init,
    input  logic signed [`ADC_IN_W-1:0]                 vinp,
    input  logic signed [`ADC_IN_W-1:0]                 vinn,
    input  logic signed [`ADC_NSLICE-1:0][`ADC_OFS_W-1:0] cal_offset,
    output logic                                        en_sync_out,
    output logic                                        sign_out,
    output logic [`ADC_OUT_W-1:0]                       adder_out,
    output logic                                        out_valid
);

    logic                                   sample_stb;
    logic [`ADC_NSLICE-1:0]                 slice_sign;
    adc_pkg::slice_mag_t [`ADC_NSLICE-1:0]  slice_mag;
    logic [`ADC_NSLICE-1:0]                 slice_valid;

    ////////////////////
    // strobe generation
    ////////////////////

    slice_sync i_sync (
        .clk_adder   (clk_adder),
        .rstb        (rstb),
        .en_slice    (en_slice),
        .en_sync_in  (en_sync_in),
        .alws_on     (alws_on),
        .init        (init),
        .en_sync_out (en_sync_out),
        .sample_stb  (sample_stb)
    );

    ////////////////////
    // comparator slices
    ////////////////////

    // every slice sees the same input and differs only in its offset
    for (genvar k = 0; k < `ADC_NSLICE; k++) begin : g_slice
        slice_quantizer i_quant (
            .clk_adder   (clk_adder),
            .rstb        (rstb),
            .sample_stb  (sample_stb),
            .vinp        (vinp),
            .vinn        (vinn),
            .cal_offset  (cal_offset[k]),
            .slice_sign  (slice_sign[k]),
            .slice_mag   (slice_mag[k]),
            .slice_valid (slice_valid[k])
        );
    end

    // slices share one strobe so slice 0 speaks for all of them
    slice_adder i_adder (
        .clk_adder   (clk_adder),
        .rstb        (rstb),
        .slice_valid (slice_valid[0]),
        .slice_sign  (slice_sign),
        .slice_mag   (slice_mag),
        .sign_out    (sign_out),
        .adder_out   (adder_out),
        .out_valid   (out_valid)
    );

endmodule

// ==== slice_adder.sv ====
// all slices must present valid results in the same cycle since one valid qualifies them all
`timescale 1ns/1ps

`include "adc_settings.svh"

module slice_adder (
    input  logic                                    clk_adder,
    input  logic                                    rstb,
    input  logic                                    slice_valid,
    input  logic [`ADC_NSLICE-1:0]                  slice_sign,
    input  adc_pkg::slice_mag_t [`ADC_NSLICE-1:0]   slice_mag,
    output logic                                    sign_out,
    output logic [`ADC_OUT_W-1:0]                   adder_out,
    output logic                                    out_valid
);

    // room for the sum of all slice magnitudes plus a sign bit
    localparam int SUM_W   = `ADC_SLICE_W + $clog2(`ADC_NSLICE) + 1;
    localparam int OUT_MAX = (1 << (`ADC_OUT_W - 1)) - 1;

    logic signed [SUM_W-1:0] sum;
    logic [SUM_W-1:0]        abs_sum;
    logic                    sum_sign;
    logic [`ADC_OUT_W-1:0]   mag_clamped;

    // sign-magnitude slices to two's complement, then accumulate
    always_comb begin
        sum = '0;
        for (int k = 0; k < `ADC_NSLICE; k++) begin
            if (slice_sign[k]) begin
                sum = sum + SUM_W'(slice_mag[k]);
            end else begin
                sum = sum - SUM_W'(slice_mag[k]);
            end
        end
    end

    assign sum_sign    = ~sum[SUM_W-1];
    assign abs_sum     = sum_sign ? sum : -sum;
    assign mag_clamped = (abs_sum > OUT_MAX) ? `ADC_OUT_W'(OUT_MAX) : `ADC_OUT_W'(abs_sum);

    ////////////////////
    // output registers
    ////////////////////

    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            out_valid <= 1'b0;
            sign_out  <= 1'b0;
            adder_out <= '0;
        end else begin
            out_valid <= slice_valid;
            if (slice_valid) begin
                sign_out  <= sum_sign;
                adder_out <= mag_clamped;
            end
        end
    end

endmodule

// ==== slice_quantizer.sv ====
// result is only updated on sample_stb and is undefined until the first strobe after reset
`timescale 1ns/1ps

`include "adc_settings.svh"

module slice_quantizer (
    input  logic                         clk_adder,
    input  logic                         rstb,
    input  logic                         sample_stb,
    input  logic signed [`ADC_IN_W-1:0]  vinp,
    input  logic signed [`ADC_IN_W-1:0]  vinn,
    input  logic signed [`ADC_OFS_W-1:0] cal_offset,
    output logic                         slice_sign,
    output adc_pkg::slice_mag_t          slice_mag,
    output logic                         slice_valid
);

    // two extra bits hold the difference plus offset without overflow
    localparam int DIFF_W  = `ADC_IN_W + 2;
    localparam int MAG_MAX = (1 << (`ADC_SLICE_W - 1)) - 1;

    logic signed [DIFF_W-1:0] diff;
    logic [DIFF_W-1:0]        abs_diff;
    logic [DIFF_W-1:0]        scaled;
    logic                     diff_sign;
    adc_pkg::slice_mag_t      mag_clamped;

    ////////////////////
    // quantizer
    ////////////////////

    assign diff = DIFF_W'(vinp) - DIFF_W'(vinn) + DIFF_W'(cal_offset);

    assign diff_sign = ~diff[DIFF_W-1];
    assign abs_diff  = diff_sign ? diff : -diff;
    assign scaled    = abs_diff >> `ADC_SLICE_SHIFT;

    // coarse slice saturates at its largest positive step
    assign mag_clamped = (scaled > DIFF_W'(MAG_MAX)) ? `ADC_SLICE_W'(MAG_MAX)
                                                      : scaled[`ADC_SLICE_W-1:0];

    ////////////////////
    // output registers
    ////////////////////

    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            slice_valid <= 1'b0;
        end else begin
            slice_valid <= sample_stb;
        end
    end

    always_ff @(posedge clk_adder) begin
        if (sample_stb) begin
            slice_sign <= diff_sign;
            slice_mag  <= mag_clamped;
        end
    end

endmodule

// ==== slice_sync.sv ====
// single clock design and en_sync_in passes through one flop only, so it must be slow or local
`timescale 1ns/1ps

`include "adc_settings.svh"

module slice_sync (
    input  logic                 clk_adder,
    input  logic                 rstb,
    input  logic                 en_slice,
    input  logic                 en_sync_in,
    input  logic                 alws_on,
    input  logic [`ADC_NDIV-1:0] init,
    output logic                 en_sync_out,
    output logic                 sample_stb
);

    logic                 en_sync_in_q;
    logic                 en_sync;
    adc_pkg::sync_state_t state;
    logic [`ADC_NDIV-1:0] count;

    ////////////////////
    // enable staging
    ////////////////////

    // first stage feeds the local enable, second goes out to the next group
    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            en_sync_in_q <= 1'b0;
            en_sync_out  <= 1'b0;
        end else begin
            en_sync_in_q <= en_sync_in;
            en_sync_out  <= en_sync_in_q;
        end
    end

    assign en_sync = en_sync_in_q & en_slice;

    ////////////////////
    // phase divider
    ////////////////////

    // count parks at init while disabled so groups can start staggered
    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            state <= adc_pkg::SYNC_OFF;
            count <= '0;
        end else if (!en_sync) begin
            state <= adc_pkg::SYNC_OFF;
            count <= init;
        end else begin
            case (state)
                adc_pkg::SYNC_OFF: begin
                    state <= adc_pkg::SYNC_ARMED;
                end
                adc_pkg::SYNC_ARMED: begin
                    state <= adc_pkg::SYNC_RUN;
                end
                adc_pkg::SYNC_RUN: begin
                    count <= count + 1'b1;
                end
                default: begin
                    state <= adc_pkg::SYNC_OFF;
                end
            endcase
        end
    end

    // strobe on every wrap of the counter, or every cycle when forced on
    assign sample_stb = (state == adc_pkg::SYNC_RUN) && ((&count) || alws_on);

endmodule

// ==== adc_pkg.sv ====
// types shared by every block of the ADC back-end; widths come from the settings header
`include "adc_settings.svh"

package adc_pkg;

    ////////////////////
    // synchronizer
    ////////////////////

    // off while disabled, one armed cycle, then free running
    typedef enum logic [1:0] {
        SYNC_OFF   = 2'd0,
        SYNC_ARMED = 2'd1,
        SYNC_RUN   = 2'd2
    } sync_state_t;

    ////////////////////
    // slice results
    ////////////////////

    // unsigned magnitude of one coarse comparator slice
    typedef logic [`ADC_SLICE_W-1:0] slice_mag_t;

endpackage

// ==== adc_settings.svh ====
// widths assume a 12 bit signed input and four slices; changing the shift alters the LSB weight
`ifndef ADC_SETTINGS_SVH
`define ADC_SETTINGS_SVH

////////////////////
// input side
////////////////////

// signed codes for vinp and vinn
`define ADC_IN_W 12

// signed calibration offset per slice
`define ADC_OFS_W 8

////////////////////
// slices
////////////////////

// slice magnitude width, saturates at 2**(w-1)-1
`define ADC_SLICE_W 4
`define ADC_SLICE_SHIFT 6
`define ADC_NSLICE 4

// output magnitude width and phase divider width
`define ADC_OUT_W 8
`define ADC_NDIV 2

`endif
